// File: list.f
rs_pkg.sv
rs_parity_symbol.sv
rs_codeword_reg.sv
rs_encoder.sv
tb_clock_gen.sv
rs_encoder_asserts.sv
rs_encoder_tb.sv

// File: rs_codeword_reg.sv
`default_nettype none

module rs_codeword_reg
  import rs_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic [msg_bits-1:0]     msg,
  input  logic                    msg_valid,
  output logic                    msg_ready,
  input  logic [symbol_width-1:0] check_0,
  input  logic [symbol_width-1:0] check_1,
  output codeword_u               code,
  output logic                    code_valid,
  input  logic                    code_ready
);

  logic accept;  // Message taken this cycle.
  logic drain;   // Held codeword leaves this cycle.

  // Free slot, or the slot empties on this very edge.
  assign msg_ready = !code_valid || code_ready;
  assign accept    = msg_valid && msg_ready;
  assign drain     = code_valid && code_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      code_valid <= 1'b0;
    end else if (accept) begin
      code_valid <= 1'b1;
    end else if (drain) begin
      code_valid <= 1'b0;
    end
  end

  // Payload only moves on a transfer, so it holds under back-pressure.
  always_ff @(posedge clk) begin
    if (accept) begin
      code.flat[code_bits-1 -: msg_bits] <= msg;  // Systematic part.
      code.sym[1]                        <= check_0;  // Parity bits 15..8.
      code.sym[0]                        <= check_1;  // Parity bits 7..0.
    end
  end

endmodule

`default_nettype wire

// File: rs_encoder.sv
`default_nettype none

// Systematic RS(18,16) encoder over 8-bit symbols with one register stage.
module rs_encoder
  import rs_pkg::*;
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic [msg_bits-1:0] msg,
  input  logic                msg_valid,
  output logic                msg_ready,
  output codeword_u           code,
  output logic                code_valid,
  input  logic                code_ready
);

  logic [symbol_width-1:0] check_0;  // From rows 0 to 7.
  logic [symbol_width-1:0] check_1;  // From rows 8 to 15.

  rs_parity_symbol #(
    .check_index (0)
  ) u_check_0 (
    .msg   (msg),
    .check (check_0)
  );

  rs_parity_symbol #(
    .check_index (1)
  ) u_check_1 (
    .msg   (msg),
    .check (check_1)
  );

  rs_codeword_reg u_codeword_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .msg        (msg),
    .msg_valid  (msg_valid),
    .msg_ready  (msg_ready),
    .check_0    (check_0),
    .check_1    (check_1),
    .code       (code),
    .code_valid (code_valid),
    .code_ready (code_ready)
  );

endmodule

`default_nettype wire

// File: rs_encoder_asserts.sv
`default_nettype none

module rs_encoder_asserts
  import rs_pkg::*;
(
  input logic                clk,
  input logic                rst_n,
  input logic [msg_bits-1:0] msg,
  input logic                msg_valid,
  input logic                msg_ready,
  input codeword_u           code,
  input logic                code_valid,
  input logic                code_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  reset_empty: assert property (@(posedge clk) !rst_n |=> !code_valid)
    else $error("code_valid is high in the cycle after reset");

  // Stalled output keeps its payload.
  hold_under_stall: assert property (@(posedge clk) disable iff (!rst_n)
    code_valid && !code_ready |=> code_valid && $stable(code))
    else $error("codeword changed while the sink stalled");

  // A taken message sits in the slot on the next cycle.
  accept_loads: assert property (@(posedge clk) disable iff (!rst_n)
    msg_valid && msg_ready |=>
      code_valid && code.flat[code_bits-1 -: msg_bits] == $past(msg))
    else $error("accepted message not in the codeword register one cycle later");

endmodule

bind rs_codeword_reg rs_encoder_asserts u_asserts (
  .clk        (clk),
  .rst_n      (rst_n),
  .msg        (msg),
  .msg_valid  (msg_valid),
  .msg_ready  (msg_ready),
  .code       (code),
  .code_valid (code_valid),
  .code_ready (code_ready)
);

`default_nettype wire

// File: rs_encoder_tb.sv
`default_nettype none

module rs_encoder_tb
  import rs_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int par_bits    = check_symbols * symbol_width;
  localparam int n_entries   = 40;
  localparam int burst_start = 28;  // No stalls from here on.
  localparam int idle_limit  = 50;
  localparam int cycle_limit = 2000;

  logic                clk;
  logic                rst_n;
  logic [msg_bits-1:0] msg;
  logic                msg_valid;
  logic                msg_ready;
  codeword_u           code;
  logic                code_valid;
  logic                code_ready;

  logic [msg_bits-1:0] msg_tab   [n_entries];
  int                  stall_tab [n_entries];  // Cycles code_ready stays low.
  logic                xor_tab   [n_entries];  // Message is XOR of previous two.
  int                  bit_tab   [n_entries];  // Single set bit, or -1.
  logic [par_bits-1:0] par_tab   [n_entries];  // Expected parity.

  logic [par_bits-1:0] dut_par [n_entries];
  logic                got_tab [n_entries];
  codeword_u           exp_code_q [$];
  int                  exp_idx_q  [$];

  int          value_errors;
  int          timeout_errors;
  logic [31:0] lcg_state;

  tb_clock_gen u_clock_gen (
    .clk (clk)
  );

  rs_encoder i_rs_encoder (
    .clk        (clk),
    .rst_n      (rst_n),
    .msg        (msg),
    .msg_valid  (msg_valid),
    .msg_ready  (msg_ready),
    .code       (code),
    .code_valid (code_valid),
    .code_ready (code_ready)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Parity bit 15 - r is the XOR of the message bits picked by row r.
  function automatic logic [par_bits-1:0] matrix_parity(input logic [msg_bits-1:0] m);
    logic [par_bits-1:0] p;
    p = '0;
    for (int r = 0; r < par_bits; r++) begin
      p[par_bits-1-r] = ^(m & parity_rows[r]);
    end
    return p;
  endfunction

  function automatic logic [par_bits-1:0] matrix_column(input int b);
    logic [par_bits-1:0] c;
    c = '0;
    for (int r = 0; r < par_bits; r++) begin
      c[par_bits-1-r] = parity_rows[r][b];
    end
    return c;
  endfunction

  function automatic logic [msg_bits-1:0] random_msg();
    logic [msg_bits-1:0] m;
    for (int w = 0; w < msg_bits / 32; w++) begin
      lcg_state     = lcg_next(lcg_state);
      m[w*32 +: 32] = lcg_state;
    end
    return m;
  endfunction

  task automatic fill_table();
    for (int i = 0; i < n_entries; i++) begin
      msg_tab[i]   = '0;
      stall_tab[i] = 0;
      xor_tab[i]   = 1'b0;
      bit_tab[i]   = -1;
      got_tab[i]   = 1'b0;
      dut_par[i]   = '0;
    end
    bit_tab[1]      = msg_bits - 1;
    msg_tab[1][127] = 1'b1;
    bit_tab[2]      = 0;
    msg_tab[2][0]   = 1'b1;
    bit_tab[3]      = 64;
    msg_tab[3][64]  = 1'b1;
    stall_tab[3]    = 2;
    xor_tab[4]      = 1'b1;
    msg_tab[5]      = '1;
    stall_tab[5]    = 3;
    msg_tab[6]      = {msg_symbols{8'hAA}};
    msg_tab[7]      = {msg_symbols{8'h55}};
    stall_tab[7]    = 1;
    xor_tab[8]      = 1'b1;
    for (int i = 9; i < n_entries; i++) begin
      msg_tab[i] = random_msg();
      if (i < burst_start) begin
        stall_tab[i] = int'(lcg_state[31:30]);
      end
      if (i % 5 == 0) begin
        xor_tab[i] = 1'b1;
      end
    end
    for (int i = 0; i < n_entries; i++) begin
      if (xor_tab[i]) begin
        msg_tab[i] = msg_tab[i-1] ^ msg_tab[i-2];
      end
      par_tab[i] = matrix_parity(msg_tab[i]);
    end
  endtask

  task automatic check_codeword(input int idx, input codeword_u expected);
    logic [par_bits-1:0] par;
    par = {code.sym[1], code.sym[0]};
    if (code.flat[code_bits-1 -: msg_bits] !== msg_tab[idx]) begin
      value_errors++;
      $display("** Error at %0t: entry %0d message part %h, expected %h",
               $time, idx, code.flat[code_bits-1 -: msg_bits], msg_tab[idx]);
    end
    if (code.sym[code_symbols-1] !== msg_tab[idx][msg_bits-1 -: symbol_width]) begin
      value_errors++;
      $display("** Error at %0t: entry %0d symbol 17 is %h, expected %h",
               $time, idx, code.sym[code_symbols-1], msg_tab[idx][msg_bits-1 -: symbol_width]);
    end
    if (par !== par_tab[idx]) begin
      value_errors++;
      $display("** Error at %0t: entry %0d parity %h, expected %h",
               $time, idx, par, par_tab[idx]);
    end
    if (code.flat !== expected.flat) begin
      value_errors++;
      $display("** Error at %0t: entry %0d codeword differs from the scoreboard", $time, idx);
    end
    if (bit_tab[idx] >= 0 && par !== matrix_column(bit_tab[idx])) begin
      value_errors++;
      $display("** Error at %0t: entry %0d parity %h is not column %0d of the matrix",
               $time, idx, par, bit_tab[idx]);
    end
    // Linearity against what the DUT gave for the two messages before.
    if (xor_tab[idx]) begin
      if (!got_tab[idx-1] || !got_tab[idx-2] ||
          par !== (dut_par[idx-1] ^ dut_par[idx-2])) begin
        value_errors++;
        $display("** Error at %0t: entry %0d parity %h is not %h xor %h",
                 $time, idx, par, dut_par[idx-1], dut_par[idx-2]);
      end
    end
    dut_par[idx] = par;
    got_tab[idx] = 1'b1;
  endtask

  initial begin
    int                   next_entry;
    int                   received;
    int                   cycles;
    int                   idle;
    int                   cur_head;
    int                   stall_left;
    int                   idx;
    logic                 prev_hold;
    logic                 prev_fire;
    logic                 in_fire;
    logic                 out_fire;
    logic                 timed_out;
    logic [code_bits-1:0] prev_code;
    codeword_u            expected;

    rst_n          = 1'b0;
    msg            = '0;
    msg_valid      = 1'b0;
    code_ready     = 1'b0;
    value_errors   = 0;
    timeout_errors = 0;
    lcg_state      = 32'd8587;
    next_entry     = 0;
    received       = 0;
    cycles         = 0;
    idle           = 0;
    cur_head       = -1;
    stall_left     = 0;
    prev_hold      = 1'b0;
    prev_fire      = 1'b0;
    timed_out      = 1'b0;
    prev_code      = '0;
    fill_table();

    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    #1;
    if (code_valid !== 1'b0 || msg_ready !== 1'b1) begin
      value_errors++;
      $display("** Error at %0t: after reset code_valid %b msg_ready %b, expected 0 and 1",
               $time, code_valid, msg_ready);
    end

    while (received < n_entries && !timed_out) begin
      @(negedge clk);
      cycles++;
      if (code_valid && exp_idx_q.size() > 0) begin
        if (exp_idx_q[0] != cur_head) begin
          cur_head   = exp_idx_q[0];  // New codeword at the output.
          stall_left = stall_tab[cur_head];
        end
        if (stall_left > 0) begin
          code_ready = 1'b0;
          stall_left--;
        end else begin
          code_ready = 1'b1;
        end
      end else begin
        code_ready = 1'b1;
      end
      if (next_entry < n_entries) begin
        msg_valid = 1'b1;
        msg       = msg_tab[next_entry];
      end else begin
        msg_valid = 1'b0;
        msg       = '0;
      end

      #1;  // Outputs settled, next rising edge is 1 ns away.
      out_fire = code_valid && code_ready;
      in_fire  = msg_valid && msg_ready;
      if (msg_ready !== (!code_valid || code_ready)) begin
        value_errors++;
        $display("** Error at %0t: msg_ready %b with code_valid %b and code_ready %b",
                 $time, msg_ready, code_valid, code_ready);
      end
      if (prev_hold && (code_valid !== 1'b1 || code.flat !== prev_code)) begin
        value_errors++;
        $display("** Error at %0t: codeword changed under back-pressure", $time);
      end
      if (prev_fire && code_valid !== 1'b1) begin
        value_errors++;
        $display("** Error at %0t: code_valid low one cycle after acceptance", $time);
      end
      if (next_entry > burst_start && msg_valid && !msg_ready) begin
        value_errors++;
        $display("** Error at %0t: entry %0d not accepted at full rate", $time, next_entry);
      end
      if (out_fire) begin
        if (exp_idx_q.size() == 0) begin
          value_errors++;
          $display("** Error at %0t: codeword delivered with nothing pending", $time);
        end else begin
          idx      = exp_idx_q.pop_front();
          expected = exp_code_q.pop_front();
          check_codeword(idx, expected);
          received++;
        end
        idle = 0;
      end else begin
        idle++;
      end
      if (in_fire) begin
        expected.flat = {msg_tab[next_entry], par_tab[next_entry]};
        exp_code_q.push_back(expected);
        exp_idx_q.push_back(next_entry);
        next_entry++;
      end
      prev_hold = code_valid && !code_ready;
      prev_code = code.flat;
      prev_fire = in_fire;
      if (idle > idle_limit || cycles > cycle_limit) begin
        timed_out = 1'b1;
        timeout_errors++;
        $display("Timeout: no codeword for %0d cycles, %0d of %0d received",
                 idle, received, n_entries);
      end
    end

    if (!timed_out) begin
      @(negedge clk);
      #1;
      if (code_valid !== 1'b0) begin
        value_errors++;
        $display("** Error at %0t: extra codeword after the last entry", $time);
      end
    end

    $display("errors: %0d value, %0d timeout", value_errors, timeout_errors);
    if (value_errors == 0 && timeout_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rs_parity_symbol.sv
`default_nettype none

// One check symbol of the code. Each output bit is the GF(2) dot product of the
// message with one generator row, so the whole symbol is a multiply-accumulate
// over GF(2^8) unrolled into binary form.
module rs_parity_symbol
  import rs_pkg::*;
#(
  parameter int check_index = 0
) (
  input  logic [msg_bits-1:0]     msg,
  output logic [symbol_width-1:0] check
);

  // First matrix row for this symbol.
  localparam int first_row = check_index * symbol_width;

  logic [msg_bits-1:0] masked [symbol_width];  // Message bits picked by each row.

  for (genvar i = 0; i < symbol_width; i++) begin : g_bit
    assign masked[i] = msg & parity_rows[first_row + i];
    // Lowest row of the group lands on the symbol MSB.
    assign check[symbol_width-1-i] = ^masked[i];
  end

endmodule

`default_nettype wire

// File: rs_pkg.sv
`default_nettype none

package rs_pkg;

  localparam int symbol_width  = 8;
  localparam int msg_symbols   = 16;
  localparam int code_symbols  = 18;
  localparam int check_symbols = code_symbols - msg_symbols;
  localparam int msg_bits      = msg_symbols * symbol_width;
  localparam int code_bits     = code_symbols * symbol_width;

  // Codeword seen as a flat vector or as symbols. Message on top, parity at the bottom.
  typedef union packed {
    logic [code_bits-1:0]                        flat;
    logic [code_symbols-1:0][symbol_width-1:0]   sym;
  } codeword_u;

  // Row r gives parity bit (15 - r). Bit 127 of a row selects the first message bit.
  localparam logic [msg_bits-1:0] parity_rows [check_symbols*symbol_width] = '{
    // Rows 0 to 7 make check symbol 0.
    {32'b01000111_11101011_10000111_10111111,
     32'b10100000_01101111_10111000_00011111,
     32'b11011111_10011011_11110000_01110111,
     32'b11011000_00110100_00001100_00000011},
    {32'b00100011_01110101_01000011_01011111,
     32'b01010000_10110111_01011100_00001111,
     32'b01101111_11001101_11111000_10111011,
     32'b01101100_00011010_00000110_10000001},
    {32'b10010001_10111010_10100001_00101111,
     32'b10101000_11011011_10101110_10000111,
     32'b10110111_11100110_01111100_11011101,
     32'b00110110_00001101_10000011_11000000},
    {32'b01001000_01011101_11010000_10010111,
     32'b11010100_11101101_01010111_01000011,
     32'b11011011_11110011_10111110_01101110,
     32'b00011011_10000110_11000001_01100000},
    {32'b11100011_11000101_01101111_01110100,
     32'b11001010_10011001_00010011_10111110,
     32'b00110010_11100010_00101111_01000000,
     32'b01010101_11110111_11101100_00110011},
    {32'b10110110_10001001_00110000_10000101,
     32'b01000101_10100011_10110001_11000000,
     32'b01000110_11101010_01100111_01010111,
     32'b01110010_11001111_01111010_00011010},
    {32'b00011100_10101111_00011111_11111101,
     32'b10000010_10111110_11100000_01111111,
     32'b01111100_01101110_11000011_11011100,
     32'b01100001_11010011_00110001_00001110},
    {32'b10001110_11010111_00001111_01111110,
     32'b01000001_11011111_01110000_00111111,
     32'b10111110_00110111_11100001_11101110,
     32'b10110000_01101001_00011000_00000111},
    // Rows 8 to 15 make check symbol 1.
    {32'b01011110_00111111_11111011_00000100,
     32'b01111100_11000001_11111111_11111000,
     32'b11011101_10000110_10111001_11000010,
     32'b10100110_01100010_00011101_00000101},
    {32'b10101111_00011111_11111101_10000010,
     32'b10111110_11100000_01111111_01111100,
     32'b01101110_11000011_11011100_01100001,
     32'b11010011_00110001_00001110_00000010},
    {32'b11010111_00001111_01111110_01000001,
     32'b11011111_01110000_00111111_10111110,
     32'b00110111_11100001_11101110_10110000,
     32'b01101001_00011000_00000111_00000001},
    {32'b11101011_10000111_10111111_10100000,
     32'b01101111_10111000_00011111_11011111,
     32'b10011011_11110000_01110111_11011000,
     32'b00110100_00001100_00000011_10000000},
    {32'b00101011_01111100_10100100_01010100,
     32'b11001011_10011101_11110000_10010111,
     32'b00010000_01111110_00000010_10101110,
     32'b10111100_01100100_10011100_01000101},
    {32'b01001011_10000001_00101001_00101110,
     32'b00011001_10001111_00000111_00110011,
     32'b01010101_00111001_10111000_10010101,
     32'b01111000_11010000_11010011_00100111},
    {32'b01111011_11111111_11101111_00010011,
     32'b11110000_00000110_11111100_11100001,
     32'b01110111_00011010_11100101_00001000,
     32'b10011010_10001010_01110100_00010110},
    {32'b10111101_01111111_11110111_00001001,
     32'b11111000_10000011_11111110_11110000,
     32'b10111011_00001101_01110010_10000100,
     32'b01001101_11000101_00111010_00001011}
  };

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Compile and run the RS encoder testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f list.f \
  --top-module rs_encoder_tb \
  -o rs_encoder_sim

status=0
./obj_dir/rs_encoder_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -qx "test passed" sim.log; then
  echo "simulation status $status, pass message found"
  exit 0
else
  echo "simulation status $status, pass message missing"
  exit 1
fi

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic clk
);
  timeunit 1ns;
  timeprecision 100ps;

  initial clk = 1'b0;

  always #2 clk = ~clk;  // 4 ns period.

endmodule

`default_nettype wire
